/* source/vu_pkg.sv */
/*
 * Vector unit shared definitions
 * Sizes of the lane array, register file and commit queue, the opcode
 * set, and the packed records that move a command through the lane
 * pipeline from operand read to writeback.
 */

`default_nettype none

package vu_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int NUM_LANES   = 4;	// SIMT lanes
	localparam int LANE_BITS   = 2;	// Lane index width
	localparam int NUM_REGS    = 8;	// Registers per lane
	localparam int REG_BITS    = 3;	// Register index width
	localparam int DATA_W      = 32;	// Data word width
	localparam int ISSUE_W     = 4;	// Issue number width
	localparam int TID_W       = 8;	// Thread ID width
	localparam int QUEUE_DEPTH = 4;	// Commit queue entries

	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [REG_BITS-1:0]  reg_idx_t;
	typedef logic [ISSUE_W-1:0]   issue_no_t;
	typedef logic [NUM_LANES-1:0] lane_mask_t;
	typedef logic [TID_W-1:0]     tid_t;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes and pipeline records
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,	// rs1 + rs2
		OP_SUB  = 3'd1,	// rs1 - rs2
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_MUL  = 3'd5,	// Low word of product
		OP_ADDS = 3'd6,	// rs1 + scalar
		OP_TID  = 3'd7	// Global thread index
	} opcode_e;

	typedef struct packed {
		logic       valid;
		opcode_e    op;
		reg_idx_t   rd;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		data_t      scalar;
		tid_t       thread_id;
		issue_no_t  issue_no;
		lane_mask_t lanes;	// Lanes that execute this command
	} command_t;

	// Read stage to execute stage
	typedef struct packed {
		logic     valid;
		opcode_e  op;
		reg_idx_t rd;
		data_t    operand_a;
		data_t    operand_b;
		data_t    scalar;
		tid_t     thread_id;
	} exec_t;

	// Execute stage to writeback
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		data_t    result;
	} wb_t;

endpackage

`default_nettype wire

/* source/lane_regfile.sv */
/*
 * Lane register file
 * Eight data registers of one lane. Two operand read ports and one
 * scalar read port, all combinational, plus one synchronous write port.
 */

`default_nettype none

module lane_regfile (
	input  wire                     clock,
	input  wire                     rst,
	input  wire  vu_pkg::reg_idx_t  rd_addr_a,	// Operand A select
	input  wire  vu_pkg::reg_idx_t  rd_addr_b,	// Operand B select
	input  wire  vu_pkg::reg_idx_t  rd_addr_s,	// Scalar read-out select
	output vu_pkg::data_t           rd_data_a,
	output vu_pkg::data_t           rd_data_b,
	output vu_pkg::data_t           rd_data_s,
	input  wire                     wr_en,
	input  wire  vu_pkg::reg_idx_t  wr_addr,
	input  wire  vu_pkg::data_t     wr_data
);

	vu_pkg::data_t regs [vu_pkg::NUM_REGS];

	////////////////////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < vu_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;	// Registers start at zero
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////////////////////

	// Reads see the old value in the write cycle
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];
	assign rd_data_s = regs[rd_addr_s];	// Visible one cycle after writeback

endmodule

`default_nettype wire

/* source/lane_alu.sv */
/*
 * Lane execute stage
 * Decodes the opcode of one lane's command and registers the result
 * into the writeback record. OP_TID depends on the lane index.
 */

`default_nettype none

module lane_alu #(
	parameter int LANE_ID = 0	// Position of this lane in the array
) (
	input  wire                    clock,
	input  wire                    rst,
	input  wire  vu_pkg::exec_t    exec,
	output vu_pkg::wb_t            wb
);

	vu_pkg::data_t result;
	vu_pkg::data_t tid_index;

	// Thread ID spread over the lanes
	assign tid_index = vu_pkg::data_t'(exec.thread_id) * vu_pkg::data_t'(vu_pkg::NUM_LANES)
		+ vu_pkg::data_t'(LANE_ID);

	always_comb begin
		case (exec.op)
			vu_pkg::OP_ADD:  result = exec.operand_a + exec.operand_b;
			vu_pkg::OP_SUB:  result = exec.operand_a - exec.operand_b;
			vu_pkg::OP_AND:  result = exec.operand_a & exec.operand_b;
			vu_pkg::OP_OR:   result = exec.operand_a | exec.operand_b;
			vu_pkg::OP_XOR:  result = exec.operand_a ^ exec.operand_b;
			vu_pkg::OP_MUL:  result = exec.operand_a * exec.operand_b;	// Low 32 bits
			vu_pkg::OP_ADDS: result = exec.operand_a + exec.scalar;
			vu_pkg::OP_TID:  result = tid_index;
			default:         result = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Result register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			wb.valid <= 1'b0;
		end else begin
			wb.valid  <= exec.valid;
			wb.rd     <= exec.rd;
			wb.result <= result;
		end
	end

	// An issued command never carries an undecodable opcode
	a_op_legal : assert property (@(posedge clock) disable iff (rst)
		exec.valid |-> !$isunknown(exec.op));

endmodule

`default_nettype wire

/* source/lane_unit.sv */
/*
 * Vector lane
 * Operand read, execute and writeback for one lane. Operands are
 * forwarded from the command in execute and from the writeback record,
 * so dependent commands can issue on consecutive cycles. A done pulse
 * marks each writeback.
 */

`default_nettype none

module lane_unit #(
	parameter int LANE_ID = 0
) (
	input  wire                       clock,
	input  wire                       rst,
	input  wire  vu_pkg::command_t    cmd,	// Valid already gated by lane mask
	input  wire  vu_pkg::reg_idx_t    scalar_reg,
	output vu_pkg::data_t             scalar_data,
	output logic                      done	// One pulse per writeback
);

	vu_pkg::data_t rf_data_a;
	vu_pkg::data_t rf_data_b;
	vu_pkg::exec_t exec_d;
	vu_pkg::exec_t exec_q;
	vu_pkg::exec_t exec_alu;	// exec_q with late forwarding applied
	vu_pkg::wb_t   wb;
	logic          fwd_a_d;
	logic          fwd_b_d;
	logic          fwd_a_q;
	logic          fwd_b_q;

	lane_regfile regfile_i (
		.clock     (clock),
		.rst       (rst),
		.rd_addr_a (cmd.rs1),
		.rd_addr_b (cmd.rs2),
		.rd_addr_s (scalar_reg),
		.rd_data_a (rf_data_a),
		.rd_data_b (rf_data_b),
		.rd_data_s (scalar_data),
		.wr_en     (wb.valid),
		.wr_addr   (wb.rd),
		.wr_data   (wb.result)
	);

	////////////////////////////////////////////////////////////////////////////
	// Operand read and forwarding
	////////////////////////////////////////////////////////////////////////////

	// A source matching the command in execute is not known yet.
	// Flag it and take it from wb one cycle later, where it lands.
	always_comb begin
		fwd_a_d = exec_q.valid && (exec_q.rd == cmd.rs1);	// Newest producer
		fwd_b_d = exec_q.valid && (exec_q.rd == cmd.rs2);
		exec_d.valid     = cmd.valid;
		exec_d.op        = cmd.op;
		exec_d.rd        = cmd.rd;
		exec_d.scalar    = cmd.scalar;
		exec_d.thread_id = cmd.thread_id;
		exec_d.operand_a = (wb.valid && wb.rd == cmd.rs1) ? wb.result : rf_data_a;
		exec_d.operand_b = (wb.valid && wb.rd == cmd.rs2) ? wb.result : rf_data_b;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			exec_q.valid <= 1'b0;
			fwd_a_q      <= 1'b0;
			fwd_b_q      <= 1'b0;
		end else begin
			exec_q  <= exec_d;
			fwd_a_q <= fwd_a_d;
			fwd_b_q <= fwd_b_d;
		end
	end

	always_comb begin
		exec_alu = exec_q;
		if (fwd_a_q) begin
			exec_alu.operand_a = wb.result;
		end
		if (fwd_b_q) begin
			exec_alu.operand_b = wb.result;
		end
	end

	lane_alu #(
		.LANE_ID (LANE_ID)
	) alu_i (
		.clock (clock),
		.rst   (rst),
		.exec  (exec_alu),
		.wb    (wb)
	);

	// Writeback edge
	always_ff @(posedge clock) begin
		if (rst) begin
			done <= 1'b0;
		end else begin
			done <= wb.valid;
		end
	end

	// Fixed latency, since a lane never stalls
	a_done_latency : assert property (@(posedge clock) disable iff (rst)
		exec_q.valid |-> ##2 done);

endmodule

`default_nettype wire

/* source/commit_agg.sv */
/*
 * Commit aggregator
 * In-order queue of accepted commands. Each entry collects the done
 * pulses of its enabled lanes; the oldest complete entry raises a commit
 * request that is held with its issue number until granted.
 */

`default_nettype none

module commit_agg (
	input  wire                        clock,
	input  wire                        rst,
	input  wire                        accept,
	input  wire  vu_pkg::issue_no_t    issue_no,
	input  wire  vu_pkg::lane_mask_t   lanes,
	input  wire  vu_pkg::lane_mask_t   lane_done,	// Writeback pulses
	output logic                       full,
	output logic                       commit_req,
	output vu_pkg::issue_no_t          commit_no,
	input  wire                        commit_grant
);

	typedef logic [$clog2(vu_pkg::QUEUE_DEPTH)-1:0]   qptr_t;
	typedef logic [$clog2(vu_pkg::QUEUE_DEPTH+1)-1:0] cnt_t;

	vu_pkg::issue_no_t  q_issue   [vu_pkg::QUEUE_DEPTH];
	vu_pkg::lane_mask_t q_mask    [vu_pkg::QUEUE_DEPTH];
	vu_pkg::lane_mask_t q_done    [vu_pkg::QUEUE_DEPTH];
	vu_pkg::lane_mask_t done_next [vu_pkg::QUEUE_DEPTH];
	logic [vu_pkg::QUEUE_DEPTH-1:0] occupied;
	logic [vu_pkg::QUEUE_DEPTH-1:0] complete;
	qptr_t head_ptr;
	qptr_t next_ptr;
	qptr_t wr_ptr;
	qptr_t cmp_ptr [vu_pkg::NUM_LANES];	// Per lane search start
	qptr_t cmp_hit [vu_pkg::NUM_LANES];	// Entry a pulse would mark
	cnt_t  count;
	logic  retire;

	assign full     = (count == cnt_t'(vu_pkg::QUEUE_DEPTH));
	assign retire   = commit_req && commit_grant;
	assign next_ptr = head_ptr + qptr_t'(1);

	////////////////////////////////////////////////////////////////////////////
	// Lane completion tracking
	////////////////////////////////////////////////////////////////////////////

	// A lane finishes in order, so its next entry is the first occupied
	// one from its pointer that contains the lane and is still open
	always_comb begin
		for (int i = 0; i < vu_pkg::QUEUE_DEPTH; i++) begin
			occupied[i] = cnt_t'(qptr_t'(qptr_t'(i) - head_ptr)) < count;
		end
		for (int l = 0; l < vu_pkg::NUM_LANES; l++) begin
			logic  found;
			qptr_t slot;
			found      = 1'b0;
			cmp_hit[l] = cmp_ptr[l];
			for (int k = 0; k < vu_pkg::QUEUE_DEPTH; k++) begin
				slot = cmp_ptr[l] + qptr_t'(k);
				if (!found && occupied[slot] && q_mask[slot][l] && !q_done[slot][l]) begin
					cmp_hit[l] = slot;
					found      = 1'b1;
				end
			end
		end
		for (int i = 0; i < vu_pkg::QUEUE_DEPTH; i++) begin
			done_next[i] = q_done[i];
		end
		for (int l = 0; l < vu_pkg::NUM_LANES; l++) begin
			if (lane_done[l]) begin
				done_next[cmp_hit[l]][l] = 1'b1;
			end
		end
		for (int i = 0; i < vu_pkg::QUEUE_DEPTH; i++) begin
			complete[i] = &(done_next[i] | ~q_mask[i]);	// Empty mask is complete
		end
	end

	// Entry payload
	always_ff @(posedge clock) begin
		if (accept) begin
			q_issue[wr_ptr] <= issue_no;
			q_mask[wr_ptr]  <= lanes;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			head_ptr   <= '0;
			wr_ptr     <= '0;
			count      <= '0;
			commit_req <= 1'b0;
			commit_no  <= '0;
			for (int i = 0; i < vu_pkg::QUEUE_DEPTH; i++) begin
				q_done[i] <= '0;
			end
			for (int l = 0; l < vu_pkg::NUM_LANES; l++) begin
				cmp_ptr[l] <= '0;
			end
		end else begin
			for (int i = 0; i < vu_pkg::QUEUE_DEPTH; i++) begin
				q_done[i] <= done_next[i];
			end
			for (int l = 0; l < vu_pkg::NUM_LANES; l++) begin
				if (lane_done[l]) begin
					cmp_ptr[l] <= cmp_hit[l] + qptr_t'(1);
				end else if (retire && cmp_ptr[l] == head_ptr) begin
					cmp_ptr[l] <= next_ptr;	// Never behind the head
				end
			end
			if (accept) begin
				q_done[wr_ptr] <= '0;	// Fresh entry
				wr_ptr         <= wr_ptr + qptr_t'(1);
			end
			if (retire) begin
				head_ptr <= next_ptr;
			end
			count <= count + cnt_t'(accept) - cnt_t'(retire);

			////////////////////////////////////////////////////////////////////////////
			// Commit request
			////////////////////////////////////////////////////////////////////////////
			if (retire) begin
				if (occupied[next_ptr] && complete[next_ptr]) begin
					commit_no <= q_issue[next_ptr];	// Back-to-back commit
				end else begin
					commit_req <= 1'b0;
				end
			end else if (!commit_req && occupied[head_ptr] && complete[head_ptr]) begin
				commit_req <= 1'b1;
				commit_no  <= q_issue[head_ptr];
			end
		end
	end

	a_req_held : assert property (@(posedge clock) disable iff (rst)
		commit_req && !commit_grant |=> commit_req && $stable(commit_no));

	a_no_overflow : assert property (@(posedge clock) disable iff (rst)
		accept |-> !full);

endmodule

`default_nettype wire

/* source/vector_unit.sv */
/*
 * SIMT vector unit
 * Broadcasts each accepted command to the enabled lanes, collects their
 * writebacks into in-order commit requests, and offers a combinational
 * read-out of any lane register.
 */

`default_nettype none

module vector_unit (
	input  wire                                 clock,
	input  wire                                 rst,
	input  wire  vu_pkg::command_t              cmd,
	output logic                                cmd_ready,
	input  wire  [vu_pkg::LANE_BITS-1:0]        scalar_lane,
	input  wire  vu_pkg::reg_idx_t              scalar_reg,
	output vu_pkg::data_t                       scalar_data,
	output logic                                commit_req,
	output vu_pkg::issue_no_t                   commit_no,
	input  wire                                 commit_grant
);

	logic               accept;
	logic               full;
	vu_pkg::lane_mask_t lane_done;
	vu_pkg::command_t   lane_cmd   [vu_pkg::NUM_LANES];
	vu_pkg::data_t      lane_sdata [vu_pkg::NUM_LANES];

	assign cmd_ready   = ~full;	// Queue space reserves room for work in flight
	assign accept      = cmd.valid & ~full;
	assign scalar_data = lane_sdata[scalar_lane];

	////////////////////////////////////////////////////////////////////////////
	// Lane array
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < vu_pkg::NUM_LANES; i++) begin : g_lane
		always_comb begin
			lane_cmd[i]       = cmd;
			lane_cmd[i].valid = accept & cmd.lanes[i];	// Lane enable
		end

		lane_unit #(
			.LANE_ID (i)
		) lane_i (
			.clock       (clock),
			.rst         (rst),
			.cmd         (lane_cmd[i]),
			.scalar_reg  (scalar_reg),
			.scalar_data (lane_sdata[i]),
			.done        (lane_done[i])
		);
	end

	// Final stage, in acceptance order
	commit_agg commit_agg_i (
		.clock        (clock),
		.rst          (rst),
		.accept       (accept),
		.issue_no     (cmd.issue_no),
		.lanes        (cmd.lanes),
		.lane_done    (lane_done),
		.full         (full),
		.commit_req   (commit_req),
		.commit_no    (commit_no),
		.commit_grant (commit_grant)
	);

endmodule

`default_nettype wire

/* verification/tb_vector_unit.sv */
/*
 * Vector unit testbench
 * Drives seeded random commands into the DUT, keeps a register model
 * per lane and an expected commit queue, and checks register read-out,
 * commit order, back-pressure and commit latency with assertions.
 */

`default_nettype none

module tb_vector_unit;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 4000;

	logic                         clock = 1'b0;
	logic                         rst;
	vu_pkg::command_t             cmd;
	logic                         cmd_ready;
	logic [vu_pkg::LANE_BITS-1:0] scalar_lane;
	vu_pkg::reg_idx_t             scalar_reg;
	vu_pkg::data_t                scalar_data;
	logic                         commit_req;
	vu_pkg::issue_no_t            commit_no;
	logic                         commit_grant;

	vu_pkg::data_t     model_regs [vu_pkg::NUM_LANES][vu_pkg::NUM_REGS];
	vu_pkg::data_t     exp_scalar;
	vu_pkg::issue_no_t exp_q [$];	// Issue numbers in acceptance order
	vu_pkg::issue_no_t exp_head = '0;
	int                exp_count = 0;
	vu_pkg::issue_no_t issue_ctr = '0;
	vu_pkg::reg_idx_t  last_rd = '0;
	string             test_name = "reset";
	int                grant_mode = 1;	// 0 low, 1 high, 2 random
	int                cycle_count = 0;
	logic              check_en = 1'b0;
	logic              probe = 1'b0;	// Marks a latency measurement

	vector_unit vector_unit_i (
		.clock        (clock),
		.rst          (rst),
		.cmd          (cmd),
		.cmd_ready    (cmd_ready),
		.scalar_lane  (scalar_lane),
		.scalar_reg   (scalar_reg),
		.scalar_data  (scalar_data),
		.commit_req   (commit_req),
		.commit_no    (commit_no),
		.commit_grant (commit_grant)
	);

	always #5 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting and timeout
	////////////////////////////////////////////////////////////////////////////

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		report_failure($sformatf("Error: %s %s expected 0x%0h actual 0x%0h", test_name, what,
			expected, actual));
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			report_failure($sformatf("Timeout in %s after %0d cycles", test_name, cycle_count));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	task automatic apply_command(input vu_pkg::command_t c);
		vu_pkg::data_t a;
		vu_pkg::data_t b;
		vu_pkg::data_t r;
		for (int l = 0; l < vu_pkg::NUM_LANES; l++) begin
			a = model_regs[l][c.rs1];
			b = model_regs[l][c.rs2];
			case (c.op)
				vu_pkg::OP_ADD:  r = a + b;
				vu_pkg::OP_SUB:  r = a - b;
				vu_pkg::OP_AND:  r = a & b;
				vu_pkg::OP_OR:   r = a | b;
				vu_pkg::OP_XOR:  r = a ^ b;
				vu_pkg::OP_MUL:  r = a * b;
				vu_pkg::OP_ADDS: r = a + c.scalar;
				default:         r = 32'(c.thread_id) * 32'd4 + 32'(l);	// OP_TID
			endcase
			if (c.lanes[l]) begin
				model_regs[l][c.rd] = r;	// Disabled lanes keep their value
			end
		end
	endtask

	// Retire before accept, matching the DUT queue count
	always @(posedge clock) begin
		if (!rst) begin
			if (commit_req && commit_grant && exp_q.size() != 0) begin
				void'(exp_q.pop_front());
			end
			if (cmd.valid && cmd_ready) begin
				apply_command(cmd);
				exp_q.push_back(cmd.issue_no);
			end
			exp_count <= exp_q.size();
			exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
		end
	end

	always_comb begin
		exp_scalar = model_regs[scalar_lane][scalar_reg];
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	a_reset_state : assert property (@(posedge clock) $fell(rst) |-> !commit_req && cmd_ready)
		else report_failure("commit_req high or cmd_ready low right after reset");

	a_scalar : assert property (@(posedge clock) disable iff (rst)
		check_en |-> scalar_data == exp_scalar)
		else report_mismatch("scalar read", $sampled(exp_scalar), $sampled(scalar_data));

	a_commit_known : assert property (@(posedge clock) disable iff (rst)
		commit_req && commit_grant |-> exp_count != 0)
		else report_failure("A commit was granted with no accepted command outstanding");

	a_commit_order : assert property (@(posedge clock) disable iff (rst)
		commit_req && commit_grant |-> commit_no == exp_head)
		else report_mismatch("commit_no", $sampled(exp_head), $sampled(commit_no));

	a_ready : assert property (@(posedge clock) disable iff (rst)
		cmd_ready == (exp_count != vu_pkg::QUEUE_DEPTH))
		else report_mismatch("cmd_ready", $sampled(exp_count != vu_pkg::QUEUE_DEPTH),
			$sampled(cmd_ready));

	a_req_hold : assert property (@(posedge clock) disable iff (rst)
		commit_req && !commit_grant |=> commit_req && $stable(commit_no))
		else report_failure("Commit request dropped or changed before its grant");

	// Low for the accept edge and three more, then high
	a_latency : assert property (@(posedge clock) disable iff (rst)
		probe && cmd.valid && cmd_ready && cmd.lanes == 4'hf && exp_count == 0
		|-> !commit_req [*4] ##1 commit_req)
		else report_failure("commit_req did not rise exactly 3 edges after the accept");

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic tick();
		@(posedge clock);
		case (grant_mode)
			0:       commit_grant <= 1'b0;
			1:       commit_grant <= 1'b1;
			default: commit_grant <= ($urandom % 4) != 0;
		endcase
	endtask

	task automatic build_cmd(input vu_pkg::lane_mask_t mask, input logic chain,
		output vu_pkg::command_t c);
		c.valid     = 1'b1;
		c.op        = vu_pkg::opcode_e'($urandom_range(7, 0));
		c.rd        = vu_pkg::reg_idx_t'($urandom);
		c.rs1       = chain ? last_rd : vu_pkg::reg_idx_t'($urandom);	// Dependent chain
		c.rs2       = (chain && $urandom % 2) ? last_rd : vu_pkg::reg_idx_t'($urandom);
		c.scalar    = $urandom;
		c.thread_id = vu_pkg::tid_t'($urandom);
		c.issue_no  = issue_ctr;
		c.lanes     = mask;
		issue_ctr   = issue_ctr + 1'b1;
		last_rd     = c.rd;
	endtask

	// Holds the command until the edge that accepts it
	task automatic send(input vu_pkg::command_t c);
		cmd <= c;
		do tick(); while (!cmd_ready);
	endtask

	task automatic drain();
		cmd.valid <= 1'b0;
		do tick(); while (exp_count != 0);
		repeat (2) tick();
	endtask

	task automatic read_all();
		cmd.valid <= 1'b0;
		check_en  <= 1'b1;
		for (int l = 0; l < vu_pkg::NUM_LANES; l++) begin
			for (int r = 0; r < vu_pkg::NUM_REGS; r++) begin
				scalar_lane <= l[vu_pkg::LANE_BITS-1:0];
				scalar_reg  <= r[vu_pkg::REG_BITS-1:0];
				tick();
			end
		end
		check_en <= 1'b0;
	endtask

	initial begin
		vu_pkg::command_t c;
		void'($urandom(32'h7989_5066));
		rst          = 1'b1;
		cmd          = '0;
		scalar_lane  = '0;
		scalar_reg   = '0;
		commit_grant = 1'b0;
		for (int l = 0; l < vu_pkg::NUM_LANES; l++) begin
			for (int r = 0; r < vu_pkg::NUM_REGS; r++) begin
				model_regs[l][r] = '0;
			end
		end
		repeat (16) @(posedge clock);
		rst <= 1'b0;
		read_all();	// All registers cleared

		test_name  = "random_ops";
		grant_mode = 2;
		for (int i = 0; i < 150; i++) begin
			build_cmd(4'hf, ($urandom % 3) != 0, c);
			send(c);
		end
		drain();
		read_all();

		test_name = "lane_masks";
		for (int i = 0; i < 150; i++) begin
			build_cmd((i % 10 == 0) ? 4'h0 : vu_pkg::lane_mask_t'($urandom), ($urandom % 2), c);
			if ($urandom % 4 == 0) begin
				c.op = vu_pkg::OP_TID;
			end
			send(c);
		end
		drain();
		read_all();

		test_name = "empty_mask_order";
		for (int i = 0; i < 8; i++) begin
			build_cmd((i % 2 == 0) ? 4'h0 : vu_pkg::lane_mask_t'($urandom), 1'b0, c);
			send(c);
		end
		drain();

		test_name  = "back_pressure";
		grant_mode = 0;
		for (int i = 0; i < vu_pkg::QUEUE_DEPTH; i++) begin
			build_cmd(4'hf, 1'b1, c);
			send(c);
		end
		build_cmd(vu_pkg::lane_mask_t'($urandom), 1'b0, c);
		cmd <= c;	// Offered while the queue is full
		repeat (20) tick();
		grant_mode = 1;
		send(c);
		drain();
		read_all();

		test_name = "commit_latency";
		for (int i = 0; i < 3; i++) begin
			build_cmd(4'hf, 1'b0, c);
			probe <= 1'b1;
			send(c);
			probe <= 1'b0;
			drain();
		end
		read_all();

		if (exp_q.size() != 0) begin
			report_failure($sformatf("%0d accepted commands were never committed", exp_q.size()));
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* vector_unit.f */
source/vu_pkg.sv
source/lane_regfile.sv
source/lane_alu.sv
source/lane_unit.sv
source/commit_agg.sv
source/vector_unit.sv
verification/tb_vector_unit.sv

/* Bender.yml */
package:
  name: vector_unit

sources:
  - source/vu_pkg.sv
  - source/lane_regfile.sv
  - source/lane_alu.sv
  - source/lane_unit.sv
  - source/commit_agg.sv
  - source/vector_unit.sv
  - target: test
    files:
      - verification/tb_vector_unit.sv
